/* rtl/vid_pkg.sv */
package vid_pkg;

    //////////////////////////////////////////////////////////////////////
    // raster timing, one set of four fields per axis
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [15:0] hsync;     // hs width in pixels
        logic [15:0] hbp;       // back porch
        logic [15:0] hactive;   // visible pixels
        logic [15:0] hfp;       // front porch
        logic [15:0] vsync;     // vs width in lines
        logic [15:0] vbp;
        logic [15:0] vactive;   // visible lines
        logic [15:0] vfp;
    } timing_t;

    //////////////////////////////////////////////////////////////////////
    // stream types
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pixel_t;

    typedef struct packed {
        logic        hs;        // positive polarity
        logic        vs;        // positive polarity
        logic        de;        // data enable
        logic [15:0] active_x;  // 1-based, 0 outside de
        logic [15:0] active_y;  // 1-based, 0 outside de
    } vid_ctrl_t;

    typedef struct packed {
        vid_ctrl_t ctrl;
        pixel_t    pix;
    } vid_beat_t;

    typedef struct packed {
        logic [31:0] pixels;    // de cycles in the frame
        logic [15:0] lines;     // lines holding any de
        logic [31:0] sum;       // r+g+b over de cycles
    } frame_stats_t;

    parameter int DEF_BAR_WIDTH  = 240;  // pixels per color bar
    parameter int DEF_OUT_STAGES = 1;    // output register depth

endpackage

/* rtl/vid_delay_line.sv */
`timescale 1ns/10ps

module vid_delay_line #(
    parameter type T     = logic [7:0],  // payload
    parameter int  DEPTH = 1             // register stages, 0 is a wire
) (
    input  logic PIXEL_CLK_I,            // pixel clock
    input  logic RESETN_I,               // sync, active low
    input  T     data_i,
    output T     data_o
);

    //////////////////////////////////////////////////////////////////////
    // register chain
    //////////////////////////////////////////////////////////////////////

    generate
        if (DEPTH == 0) begin : g_pass
            assign data_o = data_i;                  // no latency
        end else begin : g_regs
            T stage_q [DEPTH];                       // stage 0 nearest input

            always_ff @(posedge PIXEL_CLK_I) begin
                if (!RESETN_I) begin
                    for (int i = 0; i < DEPTH; i++) begin
                        stage_q[i] <= '0;            // flush whole chain
                    end
                end else begin
                    stage_q[0] <= data_i;
                    for (int i = 1; i < DEPTH; i++) begin
                        stage_q[i] <= stage_q[i-1];  // shift toward output
                    end
                end
            end

            assign data_o = stage_q[DEPTH-1];
        end
    endgenerate

endmodule

/* rtl/vid_timing_gen.sv */
`timescale 1ns/10ps

module vid_timing_gen (
    input  logic               PIXEL_CLK_I,  // pixel clock
    input  logic               RESETN_I,     // sync, active low
    input  vid_pkg::timing_t   timing_i,     // only changed under reset
    output vid_pkg::vid_ctrl_t ctrl_o        // registered raster beat
);

    //////////////////////////////////////////////////////////////////////
    // frame geometry
    //////////////////////////////////////////////////////////////////////

    logic [15:0] h_total;    // sum of horizontal fields
    logic [15:0] v_total;    // sum of vertical fields
    logic [15:0] h_blank;    // sync + back porch, last x before active
    logic [15:0] v_blank;    // same for lines
    logic [15:0] h_act_end;  // last active x
    logic [15:0] v_act_end;  // last active y

    assign h_total   = timing_i.hsync + timing_i.hbp + timing_i.hactive + timing_i.hfp;
    assign v_total   = timing_i.vsync + timing_i.vbp + timing_i.vactive + timing_i.vfp;
    assign h_blank   = timing_i.hsync + timing_i.hbp;
    assign v_blank   = timing_i.vsync + timing_i.vbp;
    assign h_act_end = h_blank + timing_i.hactive;
    assign v_act_end = v_blank + timing_i.vactive;

    //////////////////////////////////////////////////////////////////////
    // position counters
    //////////////////////////////////////////////////////////////////////

    logic [15:0] x_cnt;      // 0 in reset, then 1..h_total
    logic [15:0] y_cnt;      // 0 until first wrap, then 1..v_total

    always_ff @(posedge PIXEL_CLK_I) begin
        if (!RESETN_I) begin
            x_cnt <= '0;
        end else if (x_cnt < h_total) begin
            x_cnt <= x_cnt + 16'd1;
        end else begin
            x_cnt <= 16'd1;                      // wrap to first pixel
        end
    end

    always_ff @(posedge PIXEL_CLK_I) begin
        if (!RESETN_I) begin
            y_cnt <= '0;
        end else if (x_cnt == h_total) begin     // end of line
            if (y_cnt < v_total) begin
                y_cnt <= y_cnt + 16'd1;
            end else begin
                y_cnt <= 16'd1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // decode and output register
    //////////////////////////////////////////////////////////////////////

    logic               h_win;     // x inside active window
    logic               v_win;     // y inside active window
    vid_pkg::vid_ctrl_t ctrl_nxt;

    assign h_win = (x_cnt > h_blank) && (x_cnt <= h_act_end);
    assign v_win = (y_cnt > v_blank) && (y_cnt <= v_act_end);

    always_comb begin
        ctrl_nxt.hs       = (x_cnt >= 16'd1) && (x_cnt <= timing_i.hsync);
        ctrl_nxt.vs       = (y_cnt >= 16'd1) && (y_cnt <= timing_i.vsync);
        ctrl_nxt.de       = h_win && v_win;
        ctrl_nxt.active_x = '0;                  // gated outside de
        ctrl_nxt.active_y = '0;
        if (h_win && v_win) begin
            ctrl_nxt.active_x = x_cnt - h_blank;
            ctrl_nxt.active_y = y_cnt - v_blank;
        end
    end

    always_ff @(posedge PIXEL_CLK_I) begin
        if (!RESETN_I) begin
            ctrl_o <= '0;                        // outputs held low in reset
        end else begin
            ctrl_o <= ctrl_nxt;
        end
    end

endmodule

/* rtl/vid_bar_gen.sv */
`timescale 1ns/10ps

module vid_bar_gen #(
    parameter int BAR_WIDTH = vid_pkg::DEF_BAR_WIDTH  // pixels per bar
) (
    input  logic               PIXEL_CLK_I,  // pixel clock
    input  logic               RESETN_I,     // sync, active low
    input  vid_pkg::vid_ctrl_t ctrl_i,       // raster beat from timing gen
    output vid_pkg::pixel_t    pix_o         // painted pixel, 1 cycle later
);

    localparam logic [15:0] BW = 16'(BAR_WIDTH);

    // bar colors, left to right
    localparam vid_pkg::pixel_t C_RED     = '{r: 8'hff, g: 8'h00, b: 8'h00};
    localparam vid_pkg::pixel_t C_BLUE    = '{r: 8'h00, g: 8'h00, b: 8'hff};
    localparam vid_pkg::pixel_t C_MAGENTA = '{r: 8'hff, g: 8'h00, b: 8'hff};
    localparam vid_pkg::pixel_t C_GREEN   = '{r: 8'h00, g: 8'hff, b: 8'h00};

    //////////////////////////////////////////////////////////////////////
    // bar position tracking, no divider
    //////////////////////////////////////////////////////////////////////

    logic [15:0] bar_cnt;    // pixels painted in current bar
    logic [1:0]  bar_idx;    // index of current bar, wraps after 4
    logic [15:0] cnt_nxt;
    logic [1:0]  idx_nxt;

    always_comb begin
        cnt_nxt = bar_cnt;
        idx_nxt = bar_idx;
        if (ctrl_i.de) begin
            if (ctrl_i.active_x == 16'd1) begin      // first pixel of line
                cnt_nxt = 16'd1;
                idx_nxt = 2'd0;
            end else if (bar_cnt == BW) begin        // bar full, next color
                cnt_nxt = 16'd1;
                idx_nxt = bar_idx + 2'd1;
            end else begin
                cnt_nxt = bar_cnt + 16'd1;
            end
        end
    end

    always_ff @(posedge PIXEL_CLK_I) begin
        if (!RESETN_I) begin
            bar_cnt <= '0;
            bar_idx <= '0;
            pix_o   <= '0;
        end else begin
            bar_cnt <= cnt_nxt;
            bar_idx <= idx_nxt;
            if (!ctrl_i.de) begin
                pix_o <= '0;                         // black outside active
            end else begin
                case (idx_nxt)
                    2'd0:    pix_o <= C_RED;
                    2'd1:    pix_o <= C_BLUE;
                    2'd2:    pix_o <= C_MAGENTA;
                    default: pix_o <= C_GREEN;
                endcase
            end
        end
    end

endmodule

/* rtl/vid_frame_stats.sv */
`timescale 1ns/10ps

module vid_frame_stats (
    input  logic                  PIXEL_CLK_I,   // pixel clock
    input  logic                  RESETN_I,      // sync, active low
    input  vid_pkg::vid_beat_t    beat_i,        // output stream
    output vid_pkg::frame_stats_t stats_o,       // totals of last frame
    output logic                  frame_done_o   // 1-cycle strobe, stats valid
);

    //////////////////////////////////////////////////////////////////////
    // edge detection
    //////////////////////////////////////////////////////////////////////

    logic vs_q;          // previous vs
    logic de_q;          // previous de
    logic started;       // first frame start seen
    logic vs_rise;
    logic de_rise;       // first de of a line

    assign vs_rise = beat_i.ctrl.vs & ~vs_q;
    assign de_rise = beat_i.ctrl.de & ~de_q;

    always_ff @(posedge PIXEL_CLK_I) begin
        if (!RESETN_I) begin
            vs_q    <= 1'b0;
            de_q    <= 1'b0;
            started <= 1'b0;
        end else begin
            vs_q <= beat_i.ctrl.vs;
            de_q <= beat_i.ctrl.de;
            if (vs_rise) begin
                started <= 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // accumulators and frame-end latch
    //////////////////////////////////////////////////////////////////////

    logic [31:0] pix_acc;    // de cycles so far
    logic [15:0] line_acc;   // lines with de so far
    logic [31:0] sum_acc;    // color checksum so far
    logic [31:0] pix_sum;    // r+g+b of current beat

    assign pix_sum = 32'(beat_i.pix.r) + 32'(beat_i.pix.g) + 32'(beat_i.pix.b);

    always_ff @(posedge PIXEL_CLK_I) begin
        if (!RESETN_I) begin
            pix_acc      <= '0;
            line_acc     <= '0;
            sum_acc      <= '0;
            stats_o      <= '0;
            frame_done_o <= 1'b0;
        end else begin
            frame_done_o <= 1'b0;
            if (vs_rise) begin                       // frame boundary
                pix_acc  <= '0;
                line_acc <= '0;
                sum_acc  <= '0;
                if (started) begin                   // first edge only arms
                    stats_o      <= '{pixels: pix_acc, lines: line_acc, sum: sum_acc};
                    frame_done_o <= 1'b1;
                end
            end else if (beat_i.ctrl.de) begin
                pix_acc <= pix_acc + 32'd1;
                sum_acc <= sum_acc + pix_sum;        // wraps mod 2^32
                if (de_rise) begin
                    line_acc <= line_acc + 16'd1;
                end
            end
        end
    end

endmodule

/* rtl/vid_tpg_top.sv */
`timescale 1ns/10ps

module vid_tpg_top #(
    parameter int BAR_WIDTH  = vid_pkg::DEF_BAR_WIDTH,   // pixels per bar
    parameter int OUT_STAGES = vid_pkg::DEF_OUT_STAGES   // output regs, 0 ok
) (
    input  logic                  PIXEL_CLK_I,   // pixel clock
    input  logic                  RESETN_I,      // sync, active low
    input  vid_pkg::timing_t      timing_i,      // stable outside reset
    output vid_pkg::vid_beat_t    vid_o,         // video stream
    output vid_pkg::frame_stats_t stats_o,       // per-frame totals
    output logic                  frame_done_o   // stats strobe
);

    vid_pkg::vid_ctrl_t ctrl_raw;      // timing gen output
    vid_pkg::vid_ctrl_t ctrl_aligned;  // ctrl matched to painter latency
    vid_pkg::pixel_t    pix_painted;   // bar color
    vid_pkg::vid_beat_t beat_core;     // ctrl and pixel joined

    //////////////////////////////////////////////////////////////////////
    // producer
    //////////////////////////////////////////////////////////////////////

    vid_timing_gen u_timing (
        .PIXEL_CLK_I (PIXEL_CLK_I),
        .RESETN_I    (RESETN_I),
        .timing_i    (timing_i),
        .ctrl_o      (ctrl_raw)
    );

    vid_bar_gen #(.BAR_WIDTH(BAR_WIDTH)) u_bars (
        .PIXEL_CLK_I (PIXEL_CLK_I),
        .RESETN_I    (RESETN_I),
        .ctrl_i      (ctrl_raw),
        .pix_o       (pix_painted)
    );

    vid_delay_line #(.T(vid_pkg::vid_ctrl_t), .DEPTH(1)) u_ctrl_dly (
        .PIXEL_CLK_I (PIXEL_CLK_I),
        .RESETN_I    (RESETN_I),
        .data_i      (ctrl_raw),
        .data_o      (ctrl_aligned)
    );

    assign beat_core = '{ctrl: ctrl_aligned, pix: pix_painted};

    //////////////////////////////////////////////////////////////////////
    // output buffer and consumer
    //////////////////////////////////////////////////////////////////////

    vid_delay_line #(.T(vid_pkg::vid_beat_t), .DEPTH(OUT_STAGES)) u_out_dly (
        .PIXEL_CLK_I (PIXEL_CLK_I),
        .RESETN_I    (RESETN_I),
        .data_i      (beat_core),
        .data_o      (vid_o)
    );

    vid_frame_stats u_stats (
        .PIXEL_CLK_I  (PIXEL_CLK_I),
        .RESETN_I     (RESETN_I),
        .beat_i       (vid_o),          // measures what leaves the block
        .stats_o      (stats_o),
        .frame_done_o (frame_done_o)
    );

endmodule

/* bench/vid_tpg_properties.sv */
`timescale 1ns/10ps

module vid_tpg_properties (
    input logic               PIXEL_CLK_I,   // pixel clock
    input logic               RESETN_I,      // sync, active low
    input vid_pkg::vid_beat_t vid_o,         // output stream
    input logic               frame_done_o   // stats strobe
);

    //////////////////////////////////////////////////////////////////////
    // stream invariants
    //////////////////////////////////////////////////////////////////////

    // active window sits after sync and back porch on both axes
    a_de_no_sync: assert property (
        @(posedge PIXEL_CLK_I) disable iff (!RESETN_I)
        !(vid_o.ctrl.de && (vid_o.ctrl.hs || vid_o.ctrl.vs))
    ) else $error("de high together with a sync pulse");

    a_blank_black: assert property (
        @(posedge PIXEL_CLK_I) disable iff (!RESETN_I)
        !vid_o.ctrl.de |-> (vid_o.pix == '0)   // painter output gated by de
    ) else $error("nonzero pixel outside the active window");

    //////////////////////////////////////////////////////////////////////
    // frame statistics strobe
    //////////////////////////////////////////////////////////////////////

    a_done_pulse: assert property (
        @(posedge PIXEL_CLK_I) disable iff (!RESETN_I)
        frame_done_o |=> !frame_done_o         // single-cycle strobe
    ) else $error("frame_done_o high for two cycles in a row");

endmodule

bind vid_tpg_top vid_tpg_properties u_props (
    .PIXEL_CLK_I  (PIXEL_CLK_I),
    .RESETN_I     (RESETN_I),
    .vid_o        (vid_o),
    .frame_done_o (frame_done_o)
);

/* bench/tb_vid_tpg.sv */
`timescale 1ns/10ps

module tb_vid_tpg;

    localparam int  BAR_WIDTH    = 8;     // narrow bars so several fit in a line
    localparam int  OUT_STAGES   = 1;
    localparam int  N_EPISODES   = 6;
    localparam int  RESET_CYCLES = 16;
    localparam int  CLK_PERIOD   = 8;
    localparam int  LATENCY      = 2 + OUT_STAGES;  // counter load to vid_o
    localparam int  H_MAX        = 4 + 4 + 40 + 4;  // largest htotal
    localparam int  V_MAX        = 4 + 4 + 12 + 4;  // largest vtotal
    localparam int  EP_MAX       = RESET_CYCLES + 1 + H_MAX * (V_MAX * 3 + 1) + 2 * H_MAX + 5;
    localparam real WATCHDOG_NS  = 2.0 * N_EPISODES * EP_MAX * CLK_PERIOD;  // 2x slack

    logic                  PIXEL_CLK_I;
    logic                  RESETN_I;
    vid_pkg::timing_t      timing_i;
    vid_pkg::vid_beat_t    vid_o;
    vid_pkg::frame_stats_t stats_o;
    logic                  frame_done_o;

    integer seed;
    int     errors;
    int     checks;

    vid_tpg_top #(.BAR_WIDTH(BAR_WIDTH), .OUT_STAGES(OUT_STAGES)) uut (
        .PIXEL_CLK_I  (PIXEL_CLK_I),
        .RESETN_I     (RESETN_I),
        .timing_i     (timing_i),
        .vid_o        (vid_o),
        .stats_o      (stats_o),
        .frame_done_o (frame_done_o)
    );

    initial begin
        PIXEL_CLK_I = 1'b0;
        forever #(CLK_PERIOD / 2) PIXEL_CLK_I = ~PIXEL_CLK_I;  // 125 MHz
    end

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    function automatic int pick(input int lo, input int hi);
        integer r;
        r = $random(seed);
        return lo + ((r & 32'h7fffffff) % (hi - lo + 1));  // keep it positive
    endfunction

    function automatic vid_pkg::timing_t pick_timing(input int ep);
        vid_pkg::timing_t t;
        t.hsync   = 16'(pick(1, 4));
        t.hbp     = 16'(pick(1, 4));
        // first episode spans more than one 4-bar period
        t.hactive = 16'((ep == 0) ? pick(33, 40) : pick(8, 40));
        t.hfp     = 16'(pick(1, 4));
        t.vsync   = 16'(pick(1, 4));
        t.vbp     = 16'(pick(1, 4));
        t.vactive = 16'(pick(4, 12));
        t.vfp     = 16'(pick(1, 4));
        // odd episodes end the line inside a bar
        if ((ep % 2 == 1) && (t.hactive % BAR_WIDTH == 0)) begin
            t.hactive = (t.hactive >= 16) ? t.hactive - 16'd3 : t.hactive + 16'd3;
        end
        return t;
    endfunction

    function automatic vid_pkg::pixel_t bar_color(input int ax);
        vid_pkg::pixel_t p;
        case (((ax - 1) / BAR_WIDTH) % 4)
            0:       p = '{r: 8'hff, g: 8'h00, b: 8'h00};  // red
            1:       p = '{r: 8'h00, g: 8'h00, b: 8'hff};  // blue
            2:       p = '{r: 8'hff, g: 8'h00, b: 8'hff};  // magenta
            default: p = '{r: 8'h00, g: 8'hff, b: 8'h00};  // green
        endcase
        return p;
    endfunction

    function automatic vid_pkg::vid_beat_t model_beat(input vid_pkg::timing_t t,
                                                      input int x, input int y);
        vid_pkg::vid_beat_t b;
        int hb;
        int vb;
        hb = t.hsync + t.hbp;
        vb = t.vsync + t.vbp;
        b = '0;
        b.ctrl.hs = (x >= 1) && (x <= t.hsync);
        b.ctrl.vs = (y >= 1) && (y <= t.vsync);
        b.ctrl.de = (x > hb) && (x <= hb + t.hactive) && (y > vb) && (y <= vb + t.vactive);
        if (b.ctrl.de) begin
            b.ctrl.active_x = 16'(x - hb);
            b.ctrl.active_y = 16'(y - vb);
            b.pix           = bar_color(x - hb);
        end
        return b;
    endfunction

    function automatic vid_pkg::frame_stats_t frame_totals(input vid_pkg::timing_t t);
        vid_pkg::frame_stats_t s;
        vid_pkg::pixel_t p;
        int line_sum;
        line_sum = 0;
        for (int ax = 1; ax <= t.hactive; ax++) begin
            p = bar_color(ax);
            line_sum += p.r + p.g + p.b;
        end
        s.pixels = 32'(t.hactive * t.vactive);
        s.lines  = t.vactive;
        s.sum    = 32'(line_sum * t.vactive);
        return s;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // reporting
    //////////////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string name, input logic [79:0] exp_v,
                                   input logic [79:0] act_v);
        $display("FAILED %s expected %0h actual %0h at %0t", name, exp_v, act_v, $time);
        errors++;
    endtask

    //////////////////////////////////////////////////////////////////////
    // episodes
    //////////////////////////////////////////////////////////////////////

    task automatic hold_reset(input int ep);
        @(negedge PIXEL_CLK_I);
        RESETN_I = 1'b0;                        // may land mid frame
        timing_i = pick_timing(ep);             // only changed under reset
        repeat (RESET_CYCLES) begin
            @(negedge PIXEL_CLK_I);
            checks++;
            if (vid_o !== '0) report_mismatch("reset_vid", '0, vid_o);
            if (stats_o !== '0) report_mismatch("reset_stats", '0, stats_o);
            if (frame_done_o !== 1'b0) report_mismatch("reset_done", '0, frame_done_o);
        end
        RESETN_I = 1'b1;
    endtask

    task automatic run_raster();
        int                    htot;
        int                    vtot;
        int                    mx;
        int                    my;
        int                    old_x;
        int                    pulses;
        vid_pkg::vid_beat_t    hist [LATENCY];  // expected beats in flight
        vid_pkg::vid_beat_t    exp_b;
        vid_pkg::frame_stats_t exp_s;
        logic                  prev_vs;
        logic                  seen_start;
        logic                  pend_done;
        logic                  exp_done;
        htot = timing_i.hsync + timing_i.hbp + timing_i.hactive + timing_i.hfp;
        vtot = timing_i.vsync + timing_i.vbp + timing_i.vactive + timing_i.vfp;
        exp_s = frame_totals(timing_i);
        mx = 0;
        my = 0;
        pulses = 0;
        prev_vs = 1'b0;
        seen_start = 1'b0;
        pend_done = 1'b0;
        for (int i = 0; i < LATENCY; i++) hist[i] = '0;
        // blank line 0, three frames, then stop inside frame four
        repeat (htot * (vtot * 3 + 1) + 2 * htot + 5) begin
            @(negedge PIXEL_CLK_I);
            old_x = mx;
            mx = (mx < htot) ? mx + 1 : 1;
            if (old_x == htot) my = (my < vtot) ? my + 1 : 1;
            exp_b = hist[LATENCY-1];            // beat due on vid_o now
            exp_done = pend_done;
            pend_done = exp_b.ctrl.vs && !prev_vs && seen_start;  // first edge arms
            if (exp_b.ctrl.vs && !prev_vs) seen_start = 1'b1;
            prev_vs = exp_b.ctrl.vs;
            checks++;
            if (vid_o.ctrl.hs !== exp_b.ctrl.hs)
                report_mismatch("hs", exp_b.ctrl.hs, vid_o.ctrl.hs);
            if (vid_o.ctrl.vs !== exp_b.ctrl.vs)
                report_mismatch("vs", exp_b.ctrl.vs, vid_o.ctrl.vs);
            if (vid_o.ctrl.de !== exp_b.ctrl.de)
                report_mismatch("de", exp_b.ctrl.de, vid_o.ctrl.de);
            if (vid_o.ctrl.active_x !== exp_b.ctrl.active_x)
                report_mismatch("active_x", exp_b.ctrl.active_x, vid_o.ctrl.active_x);
            if (vid_o.ctrl.active_y !== exp_b.ctrl.active_y)
                report_mismatch("active_y", exp_b.ctrl.active_y, vid_o.ctrl.active_y);
            if (vid_o.pix !== exp_b.pix) report_mismatch("pixel", exp_b.pix, vid_o.pix);
            if (frame_done_o !== exp_done) report_mismatch("frame_done", exp_done, frame_done_o);
            if (frame_done_o === 1'b1) pulses++;  // strobes seen on the DUT
            if (exp_done) begin                 // totals of the frame just ended
                if (stats_o.pixels !== exp_s.pixels)
                    report_mismatch("stats_pixels", exp_s.pixels, stats_o.pixels);
                if (stats_o.lines !== exp_s.lines)
                    report_mismatch("stats_lines", exp_s.lines, stats_o.lines);
                if (stats_o.sum !== exp_s.sum)
                    report_mismatch("stats_sum", exp_s.sum, stats_o.sum);
            end
            for (int i = LATENCY - 1; i > 0; i--) hist[i] = hist[i-1];
            hist[0] = model_beat(timing_i, mx, my);
        end
        // frame starts two, three and four each close a frame
        if (pulses != 3) report_mismatch("frame_done_count", 3, pulses);
    endtask

    initial begin
        seed = 41;
        errors = 0;
        checks = 0;
        RESETN_I = 1'b0;
        timing_i = '0;
        for (int ep = 0; ep < N_EPISODES; ep++) begin
            hold_reset(ep);
            run_raster();
        end
        $display("summary: %0d episodes, %0d checks, %0d errors", N_EPISODES, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all episodes completed");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* vlog.f */
rtl/vid_pkg.sv
rtl/vid_delay_line.sv
rtl/vid_timing_gen.sv
rtl/vid_bar_gen.sv
rtl/vid_frame_stats.sv
rtl/vid_tpg_top.sv
bench/vid_tpg_properties.sv
bench/tb_vid_tpg.sv

/* Bender.yml */
package:
  name: vid_tpg

sources:
  # design sources in compile order
  - files:
      - rtl/vid_pkg.sv
      - rtl/vid_delay_line.sv
      - rtl/vid_timing_gen.sv
      - rtl/vid_bar_gen.sv
      - rtl/vid_frame_stats.sv
      - rtl/vid_tpg_top.sv

  # testbench and bound assertions
  - target: test
    files:
      - bench/vid_tpg_properties.sv
      - bench/tb_vid_tpg.sv
